/* design/router_pkg.sv */
/*
  Shared constants and types for the five-port mesh router.
  Flit field positions, port numbering and the request mask type live here.
*/
package router_pkg;

  // --------------------
  // Port numbering
  // --------------------

  // Router ports, including the local port
  localparam int NUM_PORTS = 5;

  // Index order used by every port array in the router
  typedef enum logic [2:0] {
    PORT_UP    = 3'd0,
    PORT_DOWN  = 3'd1,
    PORT_LEFT  = 3'd2,
    PORT_RIGHT = 3'd3,
    PORT_LOCAL = 3'd4
  } port_e;

  // One bit per port, indexed by port_e
  typedef logic [NUM_PORTS-1:0] port_mask_t;

  // --------------------
  // Flit layout
  // --------------------

  localparam int FLIT_W = 64;

  typedef logic [FLIT_W-1:0] flit_t;

  // X direction: 0 goes right, 1 goes left
  localparam int X_DIR_BIT = 62;

  // Y direction: 0 goes up, 1 goes down
  localparam int Y_DIR_BIT = 61;

  // Width of each remaining-hop field
  localparam int HOP_W = 4;

  // X hops in bits 55..52
  localparam int HOP_X_LSB = 52;

  // Y hops in bits 51..48
  localparam int HOP_Y_LSB = 48;

  // Bits 47..0 and the unused upper bits are payload
  // The router passes them through untouched

endpackage

/* design/flit_buffer.sv */
/*
  Single-entry elastic buffer on a valid/ready channel.
  A pop and a push on the same edge overwrite the entry, so it keeps full rate.
*/
`timescale 1ns/1ps

module flit_buffer (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  input  router_pkg::flit_t in_data,
  output logic              in_ready,
  output logic              out_valid,
  output router_pkg::flit_t out_data,
  input  logic              out_ready
);

  import router_pkg::*;

  logic  full;
  flit_t data_q;

  // Room when empty, or when the held flit leaves on this edge
  assign in_ready  = !full || out_ready;
  assign out_valid = full;
  assign out_data  = data_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      full   <= 1'b0;
      data_q <= '0;
    end else if (in_valid && in_ready) begin
      // Push, or pop and push at once
      full   <= 1'b1;
      data_q <= in_data;
    end else if (out_ready) begin
      // Pop with nothing behind it
      full <= 1'b0;
    end
  end

endmodule

/* design/input_port.sv */
/*
  One router input. Buffers the arriving flit, picks its output by XY routing
  and rewrites the hop count, then holds the flit until that output takes it.
*/
`timescale 1ns/1ps

module input_port #(
  // Which router port this instance serves, for debug only
  parameter router_pkg::port_e THIS_PORT = router_pkg::PORT_LOCAL
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  input  router_pkg::flit_t      in_flit,
  output logic                   in_ready,
  output router_pkg::port_mask_t route_req,
  output router_pkg::flit_t      route_flit,
  input  logic                   take
);

  import router_pkg::*;

  logic             buf_valid;
  flit_t            buf_flit;
  logic [HOP_W-1:0] hop_x;
  logic [HOP_W-1:0] hop_y;

  // --------------------
  // Input buffer
  // --------------------

  // Pops on the same edge the chosen output grants this input
  flit_buffer u_buf (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_flit),
    .in_ready  (in_ready),
    .out_valid (buf_valid),
    .out_data  (buf_flit),
    .out_ready (take)
  );

  // --------------------
  // Route computation
  // --------------------

  assign hop_x = buf_flit[HOP_X_LSB +: HOP_W];
  assign hop_y = buf_flit[HOP_Y_LSB +: HOP_W];

  // Purely combinational on the buffered flit, no added cycle
  always_comb begin
    route_req  = '0;
    route_flit = buf_flit;
    if (buf_valid) begin
      if (hop_x != '0) begin
        // X dimension first
        if (buf_flit[X_DIR_BIT]) begin
          route_req[PORT_LEFT] = 1'b1;
        end else begin
          route_req[PORT_RIGHT] = 1'b1;
        end
        route_flit[HOP_X_LSB +: HOP_W] = hop_x - 1'b1;
      end else if (hop_y != '0) begin
        // Then Y once X is done
        if (buf_flit[Y_DIR_BIT]) begin
          route_req[PORT_DOWN] = 1'b1;
        end else begin
          route_req[PORT_UP] = 1'b1;
        end
        route_flit[HOP_Y_LSB +: HOP_W] = hop_y - 1'b1;
      end else begin
        // Both counts spent, deliver here
        route_req[PORT_LOCAL] = 1'b1;
      end
    end
  end

endmodule

/* design/rr_arbiter.sv */
/*
  Round-robin arbiter with a rotating one-hot priority pointer.
  Grant is combinational; the pointer moves only when the caller signals a transfer.
*/
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int NUM_REQ = 5
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [NUM_REQ-1:0] request,
  input  logic               advance,
  output logic [NUM_REQ-1:0] grant
);

  // One-hot, marks the requester with top priority
  logic [NUM_REQ-1:0] ptr;
  logic [NUM_REQ-1:0] ptr_next;

  // First requester at or after the pointer, with wrap-around
  always_comb begin
    int  idx;
    logic found;
    grant = '0;
    found = 1'b0;
    idx   = 0;
    for (int s = 0; s < NUM_REQ; s++) begin
      if (ptr[s]) begin
        for (int k = 0; k < NUM_REQ; k++) begin
          idx = (s + k) % NUM_REQ;
          if (!found && request[idx]) begin
            grant[idx] = 1'b1;
            found      = 1'b1;
          end
        end
      end
    end
  end

  // Next priority sits one past the winner
  always_comb begin
    ptr_next = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      ptr_next[(i + 1) % NUM_REQ] = grant[i];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ptr <= NUM_REQ'(1);
    end else if (advance) begin
      ptr <= ptr_next;
    end
  end

endmodule

/* design/output_port.sv */
/*
  One router output. Arbitrates among the inputs that request it, muxes the
  winning flit into a single-entry buffer and drives the outgoing link.
*/
`timescale 1ns/1ps

module output_port #(
  parameter int NUM_REQ = 5
) (
  input  logic                   clk,
  input  logic                   reset,
  input  router_pkg::port_mask_t req,
  input  router_pkg::flit_t      flits [NUM_REQ],
  output router_pkg::port_mask_t grant,
  output logic                   out_valid,
  output router_pkg::flit_t      out_flit,
  input  logic                   out_ready
);

  import router_pkg::*;

  logic [NUM_REQ-1:0] arb_grant;
  logic               buf_ready;
  logic               push;
  flit_t              sel_flit;

  // --------------------
  // Arbitration
  // --------------------

  // Pointer rotates only when a flit really enters the buffer
  rr_arbiter #(
    .NUM_REQ (NUM_REQ)
  ) u_arb (
    .clk     (clk),
    .reset   (reset),
    .request (req),
    .advance (push),
    .grant   (arb_grant)
  );

  // A transfer needs a winner and room in the output buffer
  assign push = buf_ready & (|arb_grant);

  // Grant goes back to the inputs only when it turns into a push
  assign grant = buf_ready ? arb_grant : '0;

  // --------------------
  // Flit mux
  // --------------------

  // Grant is one-hot, so an AND-OR mux is enough
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      if (arb_grant[i]) begin
        sel_flit = sel_flit | flits[i];
      end
    end
  end

  // --------------------
  // Output buffer
  // --------------------

  // Adds the one cycle of output-side latency
  flit_buffer u_buf (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (push),
    .in_data   (sel_flit),
    .in_ready  (buf_ready),
    .out_valid (out_valid),
    .out_data  (out_flit),
    .out_ready (out_ready)
  );

endmodule

/* design/mesh_router.sv */
/*
  Five-port mesh router top. Five input ports route flits by XY order over a
  full request crossbar to five arbitrated output ports.
*/
`timescale 1ns/1ps

module mesh_router (
  input  logic                   clk,
  input  logic                   reset,

  // Incoming links, indexed by port_e
  input  router_pkg::port_mask_t in_valid,
  input  router_pkg::flit_t      in_flit [router_pkg::NUM_PORTS],
  output router_pkg::port_mask_t in_ready,

  // Outgoing links, indexed by port_e
  output router_pkg::port_mask_t out_valid,
  output router_pkg::flit_t      out_flit [router_pkg::NUM_PORTS],
  input  router_pkg::port_mask_t out_ready
);

  import router_pkg::*;

  // --------------------
  // Crossbar signals
  // --------------------

  // Row i is the one-hot request of input i
  port_mask_t route_req [NUM_PORTS];

  // Hop-rewritten flit offered by input i
  flit_t      route_flit [NUM_PORTS];

  // Row j is the grant issued by output j
  port_mask_t grant [NUM_PORTS];

  // Column views after transposition
  port_mask_t out_req [NUM_PORTS];
  port_mask_t take;

  // --------------------
  // Input side
  // --------------------

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
    input_port #(
      .THIS_PORT (port_e'(i))
    ) u_in (
      .clk        (clk),
      .reset      (reset),
      .in_valid   (in_valid[i]),
      .in_flit    (in_flit[i]),
      .in_ready   (in_ready[i]),
      .route_req  (route_req[i]),
      .route_flit (route_flit[i]),
      .take       (take[i])
    );
  end

  // --------------------
  // Request and grant wiring
  // --------------------

  // Output j sees bit j of every input's request
  // Input i pops when any output grants it, at most one can
  always_comb begin
    take = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      for (int j = 0; j < NUM_PORTS; j++) begin
        out_req[j][i] = route_req[i][j];
        take[i]       = take[i] | grant[j][i];
      end
    end
  end

  // --------------------
  // Output side
  // --------------------

  // Every output arbitrates over all five inputs
  for (genvar j = 0; j < NUM_PORTS; j++) begin : g_out
    output_port #(
      .NUM_REQ (NUM_PORTS)
    ) u_out (
      .clk       (clk),
      .reset     (reset),
      .req       (out_req[j]),
      .flits     (route_flit),
      .grant     (grant[j]),
      .out_valid (out_valid[j]),
      .out_flit  (out_flit[j]),
      .out_ready (out_ready[j])
    );
  end

endmodule

/* verif/router_checker.sv */
/*
  Scoreboard for the mesh router testbench. Predicts the output port and the
  rewritten flit of every accepted input flit and matches each output transfer.
*/
`timescale 1ns/1ps

module router_checker (
  input  logic                   clk,
  input  logic                   reset,
  input  router_pkg::port_mask_t in_valid,
  input  router_pkg::flit_t      in_flit [router_pkg::NUM_PORTS],
  input  router_pkg::port_mask_t in_ready,
  input  router_pkg::port_mask_t out_valid,
  input  router_pkg::flit_t      out_flit [router_pkg::NUM_PORTS],
  input  router_pkg::port_mask_t out_ready,
  input  logic                   check_latency,
  input  logic                   check_fairness,
  output int                     errors,
  output int                     pending,
  output int                     checked
);

  import router_pkg::*;

  // Expected transfers, three queues kept in step
  int         exp_dst [$];
  flit_t      exp_flit [$];
  int         exp_cycle [$];

  // Source tags of the last local-port outputs
  int         recent [$];

  // Output state seen on the previous edge
  port_mask_t hold_valid;
  port_mask_t hold_ready;
  flit_t      hold_flit [NUM_PORTS];

  int         cycle;
  logic       was_reset;

  initial begin
    errors     = 0;
    pending    = 0;
    checked    = 0;
    cycle      = 0;
    was_reset  = 1'b0;
    hold_valid = '0;
    hold_ready = '0;
  end

  task automatic flag_error(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errors++;
  endtask

  // --------------------
  // Reference model
  // --------------------

  // XY order: X hops are spent before any Y hop, none left means local
  function automatic int expected_port(input flit_t f);
    int hx;
    int hy;
    hx = f[HOP_X_LSB +: HOP_W];
    hy = f[HOP_Y_LSB +: HOP_W];
    if (hx > 0) return f[X_DIR_BIT] ? int'(PORT_LEFT) : int'(PORT_RIGHT);
    if (hy > 0) return f[Y_DIR_BIT] ? int'(PORT_DOWN) : int'(PORT_UP);
    return int'(PORT_LOCAL);
  endfunction

  // The hop field of the dimension just used drops by one
  function automatic flit_t expected_flit(input flit_t f);
    flit_t r;
    int    p;
    r = f;
    p = expected_port(f);
    if (p == PORT_LEFT || p == PORT_RIGHT) begin
      r[HOP_X_LSB +: HOP_W] = f[HOP_X_LSB +: HOP_W] - 4'd1;
    end else if (p == PORT_UP || p == PORT_DOWN) begin
      r[HOP_Y_LSB +: HOP_W] = f[HOP_Y_LSB +: HOP_W] - 4'd1;
    end
    return r;
  endfunction

  // --------------------
  // Monitor
  // --------------------

  always @(posedge clk) begin : watch
    int src;
    int idx;
    // Idle outputs and open inputs from the second reset edge to one edge after reset
    if (was_reset) begin
      if (out_valid !== '0) flag_error("out_valid not low around reset");
      if (in_ready !== '1) flag_error("in_ready not high around reset");
    end
    was_reset = reset;
    cycle++;
    if (reset) begin
      hold_valid = '0;
      recent.delete();
    end else begin
      // Accepted inputs become expected outputs
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (in_valid[i] && in_ready[i]) begin
          exp_dst.push_back(expected_port(in_flit[i]));
          exp_flit.push_back(expected_flit(in_flit[i]));
          exp_cycle.push_back(cycle);
          pending++;
        end
      end
      if (!check_fairness) recent.delete();
      for (int j = 0; j < NUM_PORTS; j++) begin
        // A stalled output must hold its flit
        if (hold_valid[j] && !hold_ready[j]) begin
          if (out_valid[j] !== 1'b1 || out_flit[j] !== hold_flit[j]) begin
            flag_error($sformatf("port %0d changed its flit while stalled", j));
          end
        end
        if (out_valid[j] && out_ready[j]) begin
          src = out_flit[j][15:12];
          // Head of the queue for this source and this output
          idx = -1;
          for (int k = 0; k < exp_dst.size(); k++) begin
            if (idx < 0 && exp_dst[k] == j && exp_flit[k][15:12] == src) idx = k;
          end
          if (idx < 0) begin
            flag_error($sformatf("port %0d sent unexpected flit %h", j, out_flit[j]));
          end else begin
            if (out_flit[j] !== exp_flit[idx]) begin
              flag_error($sformatf("port %0d flit %h, expected %h",
                                   j, out_flit[j], exp_flit[idx]));
            end
            if (check_latency && cycle - exp_cycle[idx] != 2) begin
              flag_error($sformatf("port %0d latency %0d cycles, expected 2",
                                   j, cycle - exp_cycle[idx]));
            end
            exp_dst.delete(idx);
            exp_flit.delete(idx);
            exp_cycle.delete(idx);
            pending--;
            checked++;
          end
          // Round robin, five backlogged sources never repeat within five
          if (check_fairness && j == PORT_LOCAL) begin
            foreach (recent[r]) begin
              if (recent[r] == src) flag_error($sformatf("source %0d served twice", src));
            end
            recent.push_back(src);
            if (recent.size() > NUM_PORTS - 1) recent.pop_front();
          end
        end
      end
      hold_valid = out_valid;
      hold_ready = out_ready;
      hold_flit  = out_flit;
    end
  end

endmodule

/* verif/router_tb.sv */
/*
  Testbench top for the mesh router. Drives seeded random traffic into all five
  inputs, lets router_checker compare outputs, and prints one line per test.
*/
`timescale 1ns/1ps

module router_tb;

  import router_pkg::*;

  // Flits per input in the random, back-pressure and fairness tests
  localparam int RAND_PER_PORT = 40;
  localparam int FAIR_PER_PORT = 20;
  localparam int TOTAL_FLITS   = NUM_PORTS * (1 + 2 * RAND_PER_PORT + FAIR_PER_PORT);
  localparam int CYCLE_LIMIT   = 40 * TOTAL_FLITS + 200;

  logic       clk;
  logic       reset;
  port_mask_t in_valid;
  flit_t      in_flit [NUM_PORTS];
  port_mask_t in_ready;
  port_mask_t out_valid;
  flit_t      out_flit [NUM_PORTS];
  port_mask_t out_ready;
  logic       check_latency;
  logic       check_fairness;
  int         err_count;
  int         pending;
  int         checked;
  int         seq [NUM_PORTS];
  int         cycles;
  int         tests_run;
  int         tests_failed;

  mesh_router dut0 (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

  router_checker chk0 (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_flit        (in_flit),
    .in_ready       (in_ready),
    .out_valid      (out_valid),
    .out_flit       (out_flit),
    .out_ready      (out_ready),
    .check_latency  (check_latency),
    .check_fairness (check_fairness),
    .errors         (err_count),
    .pending        (pending),
    .checked        (checked)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit scales with the number of flits sent
  initial cycles = 0;
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run timed out after %0d cycles, %0d flits still pending", cycles, pending);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------
  // Stimulus helpers
  // --------------------

  // Random payload and hops, source and sequence tag in bits 15..0
  function automatic flit_t make_flit(input int src, input int num, input bit local_only);
    flit_t f;
    f = {$urandom, $urandom};
    if (local_only || $urandom_range(3) == 0) f[HOP_X_LSB +: HOP_W] = '0;
    if (local_only || $urandom_range(3) == 0) f[HOP_Y_LSB +: HOP_W] = '0;
    f[15:12] = 4'(src);
    f[11:0]  = 12'(num);
    return f;
  endfunction

  // Scoreboard counts settle between rising edges
  task automatic wait_drain();
    do @(negedge clk); while (pending != 0);
    repeat (2) @(negedge clk);
  endtask

  task automatic send_single(input int src);
    @(posedge clk);
    in_valid[src] <= 1'b1;
    in_flit[src]  <= make_flit(src, seq[src], 1'b0);
    seq[src]++;
    do @(posedge clk); while (!in_ready[src]);
    in_valid[src] <= 1'b0;
    wait_drain();
  endtask

  // Per-input traffic, stall drops out_ready at random
  task automatic run_traffic(input int per_port, input bit local_only, input bit stall);
    int         left [NUM_PORTS];
    port_mask_t pend;
    int         n;
    bit         busy;
    for (int i = 0; i < NUM_PORTS; i++) left[i] = per_port;
    pend = '0;
    n    = 0;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      n++;
      for (int i = 0; i < NUM_PORTS; i++) begin
        // Valid may change only once the held flit has been taken
        if (!pend[i] || in_ready[i]) begin
          if (left[i] > 0 && (local_only || $urandom_range(3) != 0)) begin
            in_valid[i] <= 1'b1;
            in_flit[i]  <= make_flit(i, seq[i], local_only);
            seq[i]++;
            left[i]--;
            pend[i] = 1'b1;
          end else begin
            in_valid[i] <= 1'b0;
            pend[i] = 1'b0;
          end
        end
        if (left[i] > 0 || pend[i]) busy = 1'b1;
      end
      out_ready <= stall ? port_mask_t'($urandom) : '1;
      // Fairness window opens once every input is backlogged
      check_fairness <= local_only && n >= 10 && left[0] > 0;
    end
    check_fairness <= 1'b0;
    out_ready      <= '1;
    wait_drain();
  endtask

  task automatic report_test(input string name, input int errs_before);
    int n;
    n = err_count - errs_before;
    tests_run++;
    if (n == 0) begin
      $display("test %-14s ok", name);
    end else begin
      $display("test %-14s %0d errors", name, n);
      tests_failed++;
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    int errs;
    void'($urandom(33));
    reset          = 1'b1;
    in_valid       = '0;
    out_ready      = '1;
    check_latency  = 1'b0;
    check_fairness = 1'b0;
    tests_run      = 0;
    tests_failed   = 0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      in_flit[i] = '0;
      seq[i]     = 0;
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    repeat (2) @(negedge clk);
    report_test("reset", 0);

    errs = err_count;
    check_latency <= 1'b1;
    for (int i = 0; i < NUM_PORTS; i++) send_single(i);
    check_latency <= 1'b0;
    report_test("latency", errs);

    errs = err_count;
    run_traffic(RAND_PER_PORT, 1'b0, 1'b0);
    report_test("random", errs);

    errs = err_count;
    run_traffic(RAND_PER_PORT, 1'b0, 1'b1);
    report_test("backpressure", errs);

    errs = err_count;
    run_traffic(FAIR_PER_PORT, 1'b1, 1'b0);
    report_test("fairness", errs);

    $display("tests %0d, failed %0d, flits checked %0d, errors %0d",
             tests_run, tests_failed, checked, err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* mesh_router.f */
design/router_pkg.sv
design/flit_buffer.sv
design/input_port.sv
design/rr_arbiter.sv
design/output_port.sv
design/mesh_router.sv
verif/router_checker.sv
verif/router_tb.sv
